/* src/vgaPkg.sv */
// Screen coordinates are 10-bit counters and colour is 8 bits per channel
// Playfield and banner limits assume the 640x480 layout of the game
package vgaPkg;

        typedef logic [9:0] coord_t;
        typedef logic [7:0] color_t;

        typedef struct packed {
                color_t red;
                color_t green;
                color_t blue;
        } rgb_t;

        // Playfield columns, right edge excluded
        localparam coord_t PLAY_LEFT  = 10'd165;
        localparam coord_t PLAY_RIGHT = 10'd483;

        // Banner text band, bottom row excluded
        localparam int     GLYPH_W       = 8;
        localparam coord_t BANNER_TOP    = 10'd231;
        localparam coord_t BANNER_BOTTOM = 10'd247;

        // Border gradient, blue fades by one step every 8 columns
        localparam color_t GRAD_RED       = 8'h3f;
        localparam color_t GRAD_BLUE_BASE = 8'h7f;

endpackage

/* src/gamePkg.sv */
// Game-level types and constants; glyph and sprite rows come from outside
// Sprite rows are 24 pixels wide, bit 0 sits at the ship's x position
package gamePkg;

        import vgaPkg::*;

        // Codes 5 to 7 are treated as PLAY
        typedef enum logic [2:0] {
                START    = 3'd0,
                GAMEOVER = 3'd1,
                PAUSE    = 3'd2,
                PLAY     = 3'd3,
                WIN      = 3'd4
        } gameState_t;

        // Bit 7 is the leftmost glyph pixel
        typedef logic [7:0]  glyphRow_t;
        typedef logic [23:0] spriteRow_t;

        typedef struct packed {
                coord_t     drawX;
                coord_t     drawY;
                gameState_t state;
                logic       shipHit;
                coord_t     shipX;
                glyphRow_t  glyphRow;
                spriteRow_t shipWhite;
                spriteRow_t shipRed;
                spriteRow_t shipBlue;
        } pixelIn_t;

        typedef enum logic [2:0] {
                BANNER,
                SHIP_WHITE,
                SHIP_RED,
                SHIP_BLUE,
                SHIP_EMPTY,
                PLAYFIELD,
                BORDER
        } pixelLayer_t;

        typedef struct packed {
                pixelLayer_t layer;
                gameState_t  state;
                logic [6:0]  gradIndex;
        } pixelClass_t;

        ////////////////////////////////////////////////////////////////////////////
        // Banner spans, end column excluded
        localparam coord_t START_X0 = 10'd300;
        localparam coord_t START_X1 = 10'd348;
        localparam coord_t PAUSE_X0 = 10'd300;
        localparam coord_t PAUSE_X1 = 10'd340;
        localparam coord_t OVER_X0  = 10'd284;
        localparam coord_t OVER_X1  = 10'd356;
        localparam coord_t WIN_X0   = 10'd292;
        localparam coord_t WIN_X1   = 10'd356;
        // Space between the two words
        localparam coord_t GAP_X0   = 10'd316;
        localparam coord_t GAP_X1   = 10'd324;

        ////////////////////////////////////////////////////////////////////////////
        // Palette
        localparam rgb_t WHITE         = 24'hffffff;
        localparam rgb_t SHIP_RED_RGB  = 24'hff0000;
        localparam rgb_t SHIP_BLUE_RGB = 24'h0000ff;
        localparam rgb_t TINT_WHITE    = 24'hff726f;
        localparam rgb_t TINT_BLUE     = 24'h2f00ff;
        localparam rgb_t BLACK         = 24'h000000;

        // Border flash in WIN, each colour held for FLASH_FRAMES frames
        localparam int   FLASH_FRAMES    = 4;
        localparam rgb_t FLASH_COLORS[4] = '{
                24'h3f007f,
                24'h7f003f,
                24'h003f7f,
                24'h3f7f00
        };

endpackage

/* src/pixelClassifier.sv */
`timescale 1ns/1ns
// One pixel sampled per Clk; its layer is registered one cycle later
// shipX must keep the ship pixel within its 24-pixel sprite row
module pixelClassifier (
        input  logic                 Clk,
        input  logic                 arstN,
        input  gamePkg::pixelIn_t    pixelIn,
        output gamePkg::pixelClass_t pixelClass
);

        import vgaPkg::*;
        import gamePkg::*;

        coord_t      spanX0;
        coord_t      spanX1;
        logic        hasBanner;
        logic        hasGap;
        logic        inBand;
        logic        inSpan;
        logic        inGap;
        coord_t      glyphOffset;
        logic [2:0]  glyphCol;
        logic        bannerHit;
        logic        shipOn;
        coord_t      shipOffset;
        logic [4:0]  shipIdx;
        pixelLayer_t nextLayer;

        ////////////////////////////////////////////////////////////////////////////
        // Banner

        // Span of the banner text for each state
        always_comb
        begin
                hasBanner = 1'b1;
                hasGap    = 1'b0;
                spanX0    = START_X0;
                spanX1    = START_X1;
                case (pixelIn.state)
                        START:
                        begin
                                hasBanner = 1'b1;
                        end
                        PAUSE:
                        begin
                                spanX0 = PAUSE_X0;
                                spanX1 = PAUSE_X1;
                        end
                        GAMEOVER:
                        begin
                                spanX0 = OVER_X0;
                                spanX1 = OVER_X1;
                                hasGap = 1'b1;
                        end
                        WIN:
                        begin
                                spanX0 = WIN_X0;
                                spanX1 = WIN_X1;
                                hasGap = 1'b1;
                        end
                        // PLAY and unused codes
                        default:
                        begin
                                hasBanner = 1'b0;
                        end
                endcase
        end

        assign inBand      = (pixelIn.drawY >= BANNER_TOP) && (pixelIn.drawY < BANNER_BOTTOM);
        assign inSpan      = (pixelIn.drawX >= spanX0) && (pixelIn.drawX < spanX1);
        assign inGap       = hasGap && (pixelIn.drawX >= GAP_X0) && (pixelIn.drawX < GAP_X1);
        assign glyphOffset = pixelIn.drawX - spanX0;
        assign glyphCol    = 3'(glyphOffset % GLYPH_W);
        assign bannerHit   = hasBanner && inBand && inSpan && !inGap &&
                             pixelIn.glyphRow[3'd7 - glyphCol];

        ////////////////////////////////////////////////////////////////////////////
        // Ship and background

        // Ship is hidden on the start screen
        assign shipOn     = pixelIn.shipHit && (pixelIn.state != START);
        assign shipOffset = pixelIn.drawX - pixelIn.shipX;
        assign shipIdx    = shipOffset[4:0];

        always_comb
        begin
                if (bannerHit)
                        nextLayer = BANNER;
                else if (shipOn)
                begin
                        if (pixelIn.shipWhite[shipIdx])
                                nextLayer = SHIP_WHITE;
                        else if (pixelIn.shipRed[shipIdx])
                                nextLayer = SHIP_RED;
                        else if (pixelIn.shipBlue[shipIdx])
                                nextLayer = SHIP_BLUE;
                        else
                                nextLayer = SHIP_EMPTY;
                end
                else if ((pixelIn.drawX >= PLAY_LEFT) && (pixelIn.drawX < PLAY_RIGHT))
                        nextLayer = PLAYFIELD;
                else
                        nextLayer = BORDER;
        end

        always_ff @(posedge Clk or negedge arstN)
        begin
                if (!arstN)
                        pixelClass <= '{layer: BORDER, state: START, gradIndex: 7'd0};
                else
                        pixelClass <= '{layer: nextLayer, state: pixelIn.state,
                                        gradIndex: pixelIn.drawX[9:3]};
        end

        // Upstream ship hit flag must match the sprite window
        shipInRow: assert property (@(posedge Clk) disable iff (!arstN)
                pixelIn.shipHit |-> (shipOffset < coord_t'($bits(spriteRow_t))));

endmodule

/* src/winFlash.sv */
`timescale 1ns/1ns
// Frame start is the pixel at (0,0); the colour follows the count one cycle late
module winFlash (
        input  logic                Clk,
        input  logic                arstN,
        input  vgaPkg::coord_t      drawX,
        input  vgaPkg::coord_t      drawY,
        input  gamePkg::gameState_t state,
        output vgaPkg::rgb_t        flashColor
);

        import gamePkg::*;

        // Four colours of FLASH_FRAMES frames each, then wraps
        logic [3:0] frameCount;
        logic       frameStart;
        logic [1:0] colorIdx;

        assign frameStart = (drawX == '0) && (drawY == '0);
        assign colorIdx   = 2'((frameCount / FLASH_FRAMES) % 4);

        always_ff @(posedge Clk or negedge arstN)
        begin
                if (!arstN)
                begin
                        frameCount <= '0;
                        flashColor <= FLASH_COLORS[0];
                end
                else
                begin
                        if (state != WIN)
                                frameCount <= '0;
                        else if (frameStart)
                                frameCount <= frameCount + 4'd1;
                        flashColor <= FLASH_COLORS[colorIdx];
                end
        end

        // Leaving WIN restarts the flash sequence at its first colour
        flashRestarts: assert property (@(posedge Clk) disable iff (!arstN)
                ($past(state, 2) != WIN) |-> (flashColor == FLASH_COLORS[0]));

endmodule

/* src/paletteMapper.sv */
`timescale 1ns/1ns
// Colour is registered; flashColor must already be aligned with pixelClass
module paletteMapper (
        input  logic                 Clk,
        input  logic                 arstN,
        input  gamePkg::pixelClass_t pixelClass,
        input  vgaPkg::rgb_t         flashColor,
        output vgaPkg::rgb_t         vgaRgb
);

        import vgaPkg::*;
        import gamePkg::*;

        logic isOver;
        rgb_t gradColor;
        rgb_t nextRgb;

        assign isOver = (pixelClass.state == GAMEOVER);

        // Purple border, darker toward the right
        assign gradColor = '{red: GRAD_RED, green: 8'h00,
                             blue: GRAD_BLUE_BASE - {1'b0, pixelClass.gradIndex}};

        ////////////////////////////////////////////////////////////////////////////
        // Layer to colour

        always_comb
        begin
                case (pixelClass.layer)
                        BANNER:
                                nextRgb = WHITE;
                        // Ship takes a red hue after a loss
                        SHIP_WHITE:
                                nextRgb = isOver ? TINT_WHITE : WHITE;
                        SHIP_RED:
                                nextRgb = SHIP_RED_RGB;
                        SHIP_BLUE:
                                nextRgb = isOver ? TINT_BLUE : SHIP_BLUE_RGB;
                        SHIP_EMPTY, PLAYFIELD:
                                nextRgb = BLACK;
                        default:
                        begin
                                if (pixelClass.state == WIN)
                                        nextRgb = flashColor;
                                else
                                        nextRgb = gradColor;
                        end
                endcase
        end

        always_ff @(posedge Clk or negedge arstN)
        begin
                if (!arstN)
                        vgaRgb <= BLACK;
                else
                        vgaRgb <= nextRgb;
        end

        // White banner text only comes with a state that shows a banner
        bannerWhite: assert property (@(posedge Clk) disable iff (!arstN)
                (pixelClass.layer == BANNER) |->
                        (pixelClass.state inside {START, GAMEOVER, PAUSE, WIN}));

endmodule

/* src/colorMapper.sv */
`timescale 1ns/1ns
// Pixel colour pipeline, one pixel per Clk with a fixed 2-cycle latency
// No stall path; the pixel stream must never pause
module colorMapper (
        input  logic              Clk,
        input  logic              arstN,
        input  gamePkg::pixelIn_t pixelIn,
        output vgaPkg::rgb_t      vgaRgb
);

        import vgaPkg::*;
        import gamePkg::*;

        pixelClass_t pixelClass;
        rgb_t        flashColor;

        pixelClassifier pixelClassifier_inst (
                .Clk        (Clk),
                .arstN      (arstN),
                .pixelIn    (pixelIn),
                .pixelClass (pixelClass)
        );

        // Runs alongside the classifier so both arrive together
        winFlash winFlash_inst (
                .Clk        (Clk),
                .arstN      (arstN),
                .drawX      (pixelIn.drawX),
                .drawY      (pixelIn.drawY),
                .state      (pixelIn.state),
                .flashColor (flashColor)
        );

        paletteMapper paletteMapper_inst (
                .Clk        (Clk),
                .arstN      (arstN),
                .pixelClass (pixelClass),
                .flashColor (flashColor),
                .vgaRgb     (vgaRgb)
        );

endmodule

/* verif/colorMapperTb.sv */
`timescale 1ns/1ns
// Reference colour model checked 2 cycles after each pixel; inputs change on the falling edge
// Frame-start pixels (0,0) in WIN appear only in the flash tests
module colorMapperTb;

        import vgaPkg::*;
        import gamePkg::*;

        localparam int RAND_PIXELS   = 40;
        localparam int BANNER_PIXELS = 40;
        localparam int SHIP_PIXELS   = 30;
        localparam int PIPE_PIXELS   = 60;
        // Reset, 2 cycles per single pixel, flash tests, the back-to-back run, then margin
        localparam int WATCHDOG_CYCLES = 8 + 2 * (RAND_PIXELS + 5 * BANNER_PIXELS +
                                         3 * SHIP_PIXELS) + 110 + PIPE_PIXELS + 200;

        logic        Clk;
        logic        arstN;
        pixelIn_t    pixelIn;
        rgb_t        vgaRgb;
        int unsigned lcgState = 79;
        int          errorCount = 0;
        int          checkCount = 0;
        int          testCount = 0;
        int          testErrBase = 0;

        colorMapper colorMapper_inst (
                .Clk     (Clk),
                .arstN   (arstN),
                .pixelIn (pixelIn),
                .vgaRgb  (vgaRgb)
        );

        initial
        begin
                Clk = 1'b0;
                forever #2 Clk = ~Clk;
        end

        initial
        begin
                repeat (WATCHDOG_CYCLES) @(posedge Clk);
                $display("Run timed out after %0d cycles before all tests ended", WATCHDOG_CYCLES);
                $display("FAIL: see errors above");
                $finish;
        end

        ////////////////////////////////////////////////////////////////////////////
        // Random source and reference model

        function automatic int unsigned nextRand();
                lcgState = lcgState * 32'd1664525 + 32'd1013904223;
                return lcgState >> 8;
        endfunction

        function automatic int randRange(input int lo, input int hi);
                return lo + int'(nextRand() % (hi - lo + 1));
        endfunction

        // Ship always placed so that the pixel lies in its sprite row
        function automatic pixelIn_t randomPixel(input gameState_t state);
                pixelIn_t p;
                p.drawX     = coord_t'(randRange(0, 639));
                p.drawY     = coord_t'(randRange(0, 479));
                p.state     = state;
                p.shipHit   = (nextRand() & 1) != 0;
                p.shipX     = p.drawX - coord_t'(randRange(0, 23));
                p.glyphRow  = glyphRow_t'(nextRand());
                p.shipWhite = spriteRow_t'(nextRand() & nextRand());
                p.shipRed   = spriteRow_t'(nextRand());
                p.shipBlue  = spriteRow_t'(nextRand());
                return p;
        endfunction

        function automatic rgb_t modelRgb(input pixelIn_t p, input logic [1:0] flashIdx);
                coord_t     x0;
                coord_t     x1;
                coord_t     offset;
                logic [2:0] col;
                logic [4:0] shipIdx;
                logic       shown;
                logic       twoWords;
                logic       inGap;
                rgb_t       grad;
                shown    = 1'b1;
                twoWords = 1'b0;
                x0       = START_X0;
                x1       = START_X1;
                case (p.state)
                        PAUSE:
                        begin
                                x0 = PAUSE_X0;
                                x1 = PAUSE_X1;
                        end
                        GAMEOVER:
                        begin
                                x0       = OVER_X0;
                                x1       = OVER_X1;
                                twoWords = 1'b1;
                        end
                        WIN:
                        begin
                                x0       = WIN_X0;
                                x1       = WIN_X1;
                                twoWords = 1'b1;
                        end
                        START:
                                shown = 1'b1;
                        default:
                                shown = 1'b0;
                endcase
                inGap = twoWords && (p.drawX >= GAP_X0) && (p.drawX < GAP_X1);
                col   = 3'((p.drawX - x0) % GLYPH_W);
                if (shown && !inGap && (p.drawY >= BANNER_TOP) && (p.drawY < BANNER_BOTTOM) &&
                    (p.drawX >= x0) && (p.drawX < x1) && p.glyphRow[3'd7 - col])
                        return WHITE;
                if (p.shipHit && (p.state != START))
                begin
                        offset  = p.drawX - p.shipX;
                        shipIdx = offset[4:0];
                        if (p.shipWhite[shipIdx])
                                return (p.state == GAMEOVER) ? TINT_WHITE : WHITE;
                        if (p.shipRed[shipIdx])
                                return SHIP_RED_RGB;
                        if (p.shipBlue[shipIdx])
                                return (p.state == GAMEOVER) ? TINT_BLUE : SHIP_BLUE_RGB;
                        return BLACK;
                end
                if ((p.drawX >= PLAY_LEFT) && (p.drawX < PLAY_RIGHT))
                        return BLACK;
                if (p.state == WIN)
                        return FLASH_COLORS[flashIdx];
                grad.red   = GRAD_RED;
                grad.green = 8'h00;
                grad.blue  = GRAD_BLUE_BASE - color_t'(p.drawX >> 3);
                return grad;
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // Drive and compare

        task automatic checkRgb(input string name, input rgb_t expected, input rgb_t actual);
                checkCount++;
                if (actual !== expected)
                begin
                        errorCount++;
                        $display("[FAIL] %s expected %06h got %06h at %0t", name, expected,
                                 actual, $time);
                end
        endtask

        // One cycle of input, output not checked
        task automatic holdPixel(input pixelIn_t p);
                pixelIn = p;
                @(negedge Clk);
        endtask

        task automatic samplePixel(input pixelIn_t p, input logic [1:0] flashIdx);
                rgb_t expected;
                expected = modelRgb(p, flashIdx);
                pixelIn  = p;
                repeat (2) @(posedge Clk);
                @(negedge Clk);
                checkRgb("vgaRgb", expected, vgaRgb);
        endtask

        task automatic beginTest();
                testErrBase = errorCount;
        endtask

        task automatic endTest(input string name);
                testCount++;
                $display("Test %0d (%s) done with %0d errors", testCount, name,
                         errorCount - testErrBase);
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Tests

        task automatic backgroundColors();
                pixelIn_t p;
                beginTest();
                repeat (8) @(negedge Clk);
                checkRgb("vgaRgb in reset", BLACK, vgaRgb);
                arstN = 1'b1;
                repeat (RAND_PIXELS)
                begin
                        p         = randomPixel(PLAY);
                        p.shipHit = 1'b0;
                        p.drawY   = coord_t'(randRange(0, 463));
                        if (p.drawY >= BANNER_TOP)
                                p.drawY = p.drawY + 10'd16;
                        samplePixel(p, 2'd0);
                end
                endTest("reset, playfield and border");
        endtask

        // PLAY included to show that it has no banner
        task automatic bannerText();
                pixelIn_t p;
                beginTest();
                for (int s = 0; s <= 4; s++)
                begin
                        repeat (BANNER_PIXELS)
                        begin
                                p       = randomPixel(gameState_t'(3'(s)));
                                p.drawX = coord_t'(randRange(276, 363));
                                p.shipX = p.drawX - coord_t'(randRange(0, 23));
                                p.drawY = coord_t'(randRange(231, 246));
                                samplePixel(p, 2'd0);
                        end
                end
                endTest("banner text per state");
        endtask

        task automatic shipLayers();
                pixelIn_t p;
                beginTest();
                repeat (SHIP_PIXELS)
                begin
                        p         = randomPixel(PLAY);
                        p.shipHit = 1'b1;
                        p.drawY   = coord_t'(randRange(250, 479));
                        samplePixel(p, 2'd0);
                        p.state = GAMEOVER;
                        samplePixel(p, 2'd0);
                        p.state = START;
                        samplePixel(p, 2'd0);
                end
                endTest("ship layers and tint");
        endtask

        task automatic flashSequence();
                pixelIn_t border;
                pixelIn_t frameStart;
                beginTest();
                frameStart       = '0;
                frameStart.state = WIN;
                for (int k = 0; k <= 9; k++)
                begin
                        border       = '0;
                        border.state = PLAY;
                        // Frame counter back to 0
                        holdPixel(border);
                        repeat (k) holdPixel(frameStart);
                        border.state = WIN;
                        border.drawX = coord_t'(randRange(0, 164));
                        border.drawY = coord_t'(randRange(1, 479));
                        samplePixel(border, 2'((k / FLASH_FRAMES) % 4));
                end
                endTest("WIN border flash");
        endtask

        task automatic leaveWin();
                pixelIn_t playPix;
                pixelIn_t frameStart;
                pixelIn_t border;
                beginTest();
                frameStart       = '0;
                frameStart.state = WIN;
                playPix          = '0;
                playPix.state    = PLAY;
                border           = '0;
                border.state     = WIN;
                border.drawX     = 10'd600;
                border.drawY     = 10'd20;
                repeat (2)
                begin
                        holdPixel(playPix);
                        repeat (randRange(4, 12)) holdPixel(frameStart);
                        holdPixel(playPix);
                        samplePixel(border, 2'd0);
                end
                endTest("flash restart after leaving WIN");
        endtask

        // Row 0 avoided so no WIN pixel starts a frame
        task automatic backToBack();
                rgb_t     expectQ[$];
                pixelIn_t p;
                beginTest();
                p       = '0;
                p.state = PLAY;
                holdPixel(p);
                for (int j = 0; j < PIPE_PIXELS + 2; j++)
                begin
                        if (j >= 2)
                                checkRgb("vgaRgb", expectQ.pop_front(), vgaRgb);
                        if (j < PIPE_PIXELS)
                        begin
                                p       = randomPixel(gameState_t'(3'(randRange(0, 4))));
                                p.drawY = coord_t'(randRange(1, 479));
                                expectQ.push_back(modelRgb(p, 2'd0));
                        end
                        pixelIn = p;
                        @(negedge Clk);
                end
                endTest("back-to-back pixels");
        endtask

        initial
        begin
                arstN   = 1'b0;
                pixelIn = '0;
                backgroundColors();
                bannerText();
                shipLayers();
                flashSequence();
                leaveWin();
                backToBack();
                $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
                if (errorCount == 0)
                        $display("PASS: all tests");
                else
                        $display("FAIL: see errors above");
                $finish;
        end

endmodule

/* sources.f */
src/vgaPkg.sv
src/gamePkg.sv
src/pixelClassifier.sv
src/winFlash.sv
src/paletteMapper.sv
src/colorMapper.sv
verif/colorMapperTb.sv

/* Makefile */
# Verilator build and run of the colour pipeline testbench
TOP := colorMapperTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
